// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: burst_engine.sv
// burst side of the data cache
// issues write-back and fill commands to the RAM and steps through the beats

`timescale 1ns/1ns
`default_nettype none

module burst_engine
  import cache_pkg::*;
#(
  parameter int ram_addr_bits = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_write_back,
  input  logic                     start_fill,
  input  logic [ram_addr_bits-1:0] victim_addr,
  input  logic [ram_addr_bits-1:0] fill_addr,
  input  beat_t                    wb_beat,
  input  beat_t                    br_rd_data,
  input  logic                     br_rd_data_valid,
  input  logic                     br_busy,
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [ram_addr_bits-1:0] br_addr,
  output beat_t                    br_wr_data,
  output beat_ix_t                 beat_ix,
  output logic                     fill_valid,
  output logic                     burst_done
);

  localparam beat_ix_t last_beat = beat_ix_t'(beats_per_line - 1);

  // starts wait here until the RAM is free
  logic pend_wb;
  logic pend_fill;
  // a burst is in flight
  logic wb_active;
  logic fill_active;

  // command goes out in the first cycle the RAM is not busy
  assign br_cmd_en = (pend_wb || pend_fill) && !br_busy;
  // 1 = write
  assign br_cmd = pend_wb;
  assign br_addr = pend_wb ? victim_addr : fill_addr;

  // beat 0 sits on the bus with the command, the store follows beat_ix
  assign br_wr_data = wb_beat;

  // read beats may come with gaps, each valid cycle is the next one
  assign fill_valid = fill_active && br_rd_data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_wb <= 1'b0;
      pend_fill <= 1'b0;
      wb_active <= 1'b0;
      fill_active <= 1'b0;
      beat_ix <= '0;
      burst_done <= 1'b0;
    end else begin
      burst_done <= 1'b0;
      if (start_write_back) begin
        pend_wb <= 1'b1;
      end
      if (start_fill) begin
        pend_fill <= 1'b1;
      end
      if (br_cmd_en) begin
        pend_wb <= 1'b0;
        pend_fill <= 1'b0;
        wb_active <= br_cmd;
        fill_active <= !br_cmd;
        // beat 0 of a write leaves with the command itself
        if (br_cmd) begin
          beat_ix <= beat_ix_t'(1);
        end
      end
      // write beats on consecutive cycles, read beats on valid cycles
      if (wb_active || fill_valid) begin
        beat_ix <= beat_ix + 1'b1;
        if (beat_ix == last_beat) begin
          wb_active <= 1'b0;
          fill_active <= 1'b0;
          burst_done <= 1'b1;
        end
      end
    end
  end

  // RAM rule, also no new command while a burst is still running
  a_cmd_when_free: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |-> !br_busy && !wb_active && !fill_active);

  // read data only shows up inside a fill and carries known bits
  a_rd_in_fill: assert property (@(posedge clk) disable iff (rst)
    br_rd_data_valid |-> fill_active && !$isunknown(br_rd_data));

endmodule

`default_nettype wire

// File: cache_ctrl.sv
// request FSM of the data cache
// hits finish at once, misses go through write-back and fill before finish

`timescale 1ns/1ns
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int line_ix_bits = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  input  logic is_write,
  input  logic hit,
  input  logic dirty,
  input  logic burst_done,
  output logic busy,
  output logic data_out_ready,
  output logic merge_word,
  output logic set_line,
  output logic set_dirty,
  output logic start_write_back,
  output logic start_fill
);

  cache_state_e state;
  logic accept;
  logic miss;

  // the address split in the top needs at least two lines
  if (line_ix_bits < 1) begin : g_geometry_check
    $error("cache needs at least one line index bit");
  end

  // requests are only taken in idle, where busy is low
  assign accept = enable && (state == idle);
  assign miss = accept && !hit;

  // write bytes go in on a hit or once the new line is complete
  assign merge_word = is_write && ((accept && hit) || (state == finish));
  assign set_dirty = merge_word;

  // new tag is loaded once the old line is no longer needed
  // clean miss at once, dirty miss after the write-back
  assign set_line = (miss && !dirty) || ((state == write_back) && burst_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      start_write_back <= 1'b0;
      start_fill <= 1'b0;
    end else begin
      // single-cycle pulses
      data_out_ready <= 1'b0;
      start_write_back <= 1'b0;
      start_fill <= 1'b0;
      case (state)
        idle: begin
          if (accept) begin
            if (hit) begin
              // read hit answers on the next edge
              data_out_ready <= !is_write;
            end else begin
              busy <= 1'b1;
              if (dirty) begin
                state <= write_back;
                start_write_back <= 1'b1;
              end else begin
                state <= fill;
                start_fill <= 1'b1;
              end
            end
          end
        end
        write_back: begin
          if (burst_done) begin
            state <= fill;
            start_fill <= 1'b1;
          end
        end
        fill: begin
          if (burst_done) begin
            state <= finish;
          end
        end
        finish: begin
          // ready pulse and falling busy line up
          state <= idle;
          busy <= 1'b0;
          data_out_ready <= !is_write;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // one burst is requested at a time
  a_one_start: assert property (@(posedge clk) disable iff (rst)
    !(start_write_back && start_fill));

  a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
    (state == idle) |-> !busy);

endmodule

`default_nettype wire

// File: cache_pkg.sv
// shared types and line geometry for the direct-mapped write-back data cache
// one line is eight words, moved to and from the RAM as four 64-bit beats

`default_nettype none

package cache_pkg;

  // low address bits that select a byte inside a word, ignored by the cache
  localparam int byte_offset_bits = 2;
  // word index within a line, eight words per line
  localparam int word_ix_bits = 3;
  // a line travels as one burst of this many beats
  localparam int beats_per_line = 4;
  // two words share one RAM beat, lower word in the low half
  localparam int words_per_beat = 2;

  // byte address from the requester
  typedef logic [31:0] addr_t;
  // one cached word
  typedef logic [31:0] word_t;
  // per-byte write enables, all zero means a read
  typedef logic [3:0] byte_en_t;
  // one RAM burst beat
  typedef logic [63:0] beat_t;
  // per-byte mask of a beat
  typedef logic [7:0] beat_mask_t;
  typedef logic [word_ix_bits-1:0] word_ix_t;
  typedef logic [$clog2(beats_per_line)-1:0] beat_ix_t;

  // request FSM
  // write_back and fill each cover one burst, finish completes the request
  typedef enum logic [1:0] {
    idle,
    write_back,
    fill,
    finish
  } cache_state_e;

endpackage

`default_nettype wire

// File: cache_store.sv
// line storage of the data cache with valid, dirty and tag per line
// combinational hit check and reads, byte-merge writes and fill beats at the edge

`timescale 1ns/1ns
`default_nettype none

module cache_store
  import cache_pkg::*;
#(
  parameter int line_ix_bits = 1,
  localparam int tag_bits = $bits(addr_t) - line_ix_bits - word_ix_bits - byte_offset_bits
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [line_ix_bits-1:0] line_ix,
  input  logic [tag_bits-1:0]     tag,
  input  word_ix_t                word_ix,
  input  logic                    merge_word,
  input  byte_en_t                byte_en,
  input  word_t                   wr_word,
  input  logic                    set_line,
  input  logic                    set_dirty,
  input  logic                    fill_valid,
  input  beat_ix_t                fill_beat_ix,
  input  beat_t                   fill_beat,
  input  beat_ix_t                wb_beat_ix,
  output logic                    hit,
  output logic                    dirty,
  output logic [tag_bits-1:0]     victim_tag,
  output word_t                   rd_word,
  output beat_t                   wb_beat
);

  localparam int line_count = 2 ** line_ix_bits;
  localparam int words_per_line = 2 ** word_ix_bits;
  localparam int word_bits = $bits(word_t);

  logic [line_count-1:0] line_valid;
  logic [line_count-1:0] line_dirty;
  logic [tag_bits-1:0]   line_tag [line_count];
  word_t                 line_data [line_count][words_per_line];

  // lookup of the addressed line
  assign hit = line_valid[line_ix] && (line_tag[line_ix] == tag);
  // only a valid line can need a write-back
  assign dirty = line_valid[line_ix] && line_dirty[line_ix];
  assign victim_tag = line_tag[line_ix];
  assign rd_word = line_data[line_ix][word_ix];

  // old line beat picked by the burst engine during write-back
  always_comb begin
    for (int w = 0; w < words_per_beat; w++) begin
      wb_beat[w*word_bits +: word_bits] =
        line_data[line_ix][word_ix_t'(wb_beat_ix * words_per_beat + w)];
    end
  end

  // line state, cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
      line_dirty <= '0;
    end else begin
      // new line comes in clean
      if (set_line) begin
        line_valid[line_ix] <= 1'b1;
        line_dirty[line_ix] <= 1'b0;
      end
      if (set_dirty) begin
        line_dirty[line_ix] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (set_line) begin
      line_tag[line_ix] <= tag;
    end
  end

  // fill beats and requester bytes land in the addressed line
  always_ff @(posedge clk) begin
    if (fill_valid) begin
      for (int w = 0; w < words_per_beat; w++) begin
        line_data[line_ix][word_ix_t'(fill_beat_ix * words_per_beat + w)] <=
          fill_beat[w*word_bits +: word_bits];
      end
    end
    if (merge_word) begin
      for (int b = 0; b < $bits(byte_en_t); b++) begin
        if (byte_en[b]) begin
          line_data[line_ix][word_ix][b*8 +: 8] <= wr_word[b*8 +: 8];
        end
      end
    end
  end

  // a merge only happens on a hit or after the fill has ended
  a_no_merge_in_fill: assert property (@(posedge clk) disable iff (rst)
    !(merge_word && fill_valid));

endmodule

`default_nettype wire

// File: data_cache.sv
// direct-mapped write-back data cache between a word requester and a burst RAM
// top level, splits the address and ties the store, FSM and burst engine together

`timescale 1ns/1ns
`default_nettype none

module data_cache
  import cache_pkg::*;
#(
  parameter int line_ix_bits = 1,
  parameter int ram_addr_bits = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable,
  input  addr_t                    address,
  input  byte_en_t                 write_enable_bytes,
  input  word_t                    data_in,
  output word_t                    data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [ram_addr_bits-1:0] br_addr,
  output beat_t                    br_wr_data,
  output beat_mask_t               br_data_mask,
  input  beat_t                    br_rd_data,
  input  logic                     br_rd_data_valid,
  input  logic                     br_busy
);

  localparam int tag_bits = $bits(addr_t) - line_ix_bits - word_ix_bits - byte_offset_bits;
  // lowest address bit of the line index
  localparam int line_lsb = byte_offset_bits + word_ix_bits;
  // byte address to RAM beat address
  localparam int beat_shift = byte_offset_bits + $clog2(words_per_beat);

  // |tag|line|word|byte|
  logic [tag_bits-1:0]      tag;
  logic [line_ix_bits-1:0]  line_ix;
  word_ix_t                 word_ix;
  logic [tag_bits-1:0]      victim_tag;
  addr_t                    fill_line;
  addr_t                    victim_line;
  logic [ram_addr_bits-1:0] fill_addr;
  logic [ram_addr_bits-1:0] victim_addr;
  logic     is_write;
  logic     hit;
  logic     dirty;
  logic     merge_word;
  logic     set_line;
  logic     set_dirty;
  logic     start_write_back;
  logic     start_fill;
  logic     fill_valid;
  logic     burst_done;
  beat_ix_t beat_ix;
  beat_t    wb_beat;
  word_t    rd_word;

  assign word_ix = address[byte_offset_bits +: word_ix_bits];
  assign line_ix = address[line_lsb +: line_ix_bits];
  assign tag = address[$bits(addr_t)-1 -: tag_bits];
  assign is_write = |write_enable_bytes;

  // line base addresses, requested line and the one being evicted
  assign fill_line = {tag, line_ix, {line_lsb{1'b0}}};
  assign victim_line = {victim_tag, line_ix, {line_lsb{1'b0}}};
  assign fill_addr = fill_line[beat_shift +: ram_addr_bits];
  assign victim_addr = victim_line[beat_shift +: ram_addr_bits];

  // whole beats are always written
  assign br_data_mask = '1;

  // data_out tracks the addressed word of a pending read, valid with data_out_ready
  always_ff @(posedge clk) begin
    if (enable && !is_write) begin
      data_out <= rd_word;
    end
  end

  cache_store #(.line_ix_bits(line_ix_bits)) i_cache_store (
    .clk, .rst, .line_ix, .tag, .word_ix, .merge_word,
    .byte_en(write_enable_bytes), .wr_word(data_in), .set_line, .set_dirty,
    .fill_valid, .fill_beat_ix(beat_ix), .fill_beat(br_rd_data), .wb_beat_ix(beat_ix),
    .hit, .dirty, .victim_tag, .rd_word, .wb_beat
  );

  cache_ctrl #(.line_ix_bits(line_ix_bits)) i_cache_ctrl (
    .clk, .rst, .enable, .is_write, .hit, .dirty, .burst_done, .busy, .data_out_ready,
    .merge_word, .set_line, .set_dirty, .start_write_back, .start_fill
  );

  burst_engine #(.ram_addr_bits(ram_addr_bits)) i_burst_engine (
    .clk, .rst, .start_write_back, .start_fill, .victim_addr, .fill_addr, .wb_beat,
    .br_rd_data, .br_rd_data_valid, .br_busy, .br_cmd, .br_cmd_en, .br_addr,
    .br_wr_data, .beat_ix, .fill_valid, .burst_done
  );

endmodule

`default_nettype wire

// File: list.f
cache_pkg.sv
cache_store.sv
burst_engine.sv
cache_ctrl.sv
data_cache.sv
tb_burst_ram.sv
tb_data_cache.sv

// File: tb_burst_ram.sv
// behavioral burst RAM for the data cache testbench
// four-beat bursts, fixed read latency, random busy time after each command

`timescale 1ns/1ns
`default_nettype none

module tb_burst_ram
  import cache_pkg::*;
#(
  parameter int addr_bits = 8,
  parameter int busy_seed = 32'h684f
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 br_cmd,
  input  logic                 br_cmd_en,
  input  logic [addr_bits-1:0] br_addr,
  input  beat_t                br_wr_data,
  input  beat_mask_t           br_data_mask,
  output beat_t                br_rd_data,
  output logic                 br_rd_data_valid,
  output logic                 br_busy
);

  localparam int depth = 2 ** addr_bits;
  localparam word_t pattern_xor = 32'h5a5a0000;

  beat_t mem [depth];
  int seed;
  // burst progress
  logic [addr_bits-1:0] wr_ptr;
  logic [addr_bits-1:0] rd_ptr;
  int wr_left;
  int rd_left;
  int rd_delay;
  int busy_left;
  // bus values taken at the edge
  logic cmd_en_s;
  logic cmd_s;
  logic [addr_bits-1:0] addr_s;
  beat_t wr_data_s;
  beat_mask_t mask_s;

  task automatic write_beat(input logic [addr_bits-1:0] a, input beat_t d, input beat_mask_t m);
    for (int b = 0; b < $bits(beat_mask_t); b++) begin
      if (m[b]) begin
        mem[a][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  // word n holds n xor pattern, lower word of a beat in the low half
  initial begin
    seed = busy_seed;
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    br_busy = 1'b0;
    wr_ptr = '0;
    rd_ptr = '0;
    wr_left = 0;
    rd_left = 0;
    rd_delay = 0;
    busy_left = 0;
    for (int n = 0; n < depth; n++) begin
      mem[n] = {word_t'(2 * n + 1) ^ pattern_xor, word_t'(2 * n) ^ pattern_xor};
    end
  end

  always @(posedge clk) begin
    cmd_en_s = br_cmd_en && !rst;
    cmd_s = br_cmd;
    addr_s = br_addr;
    wr_data_s = br_wr_data;
    mask_s = br_data_mask;
    #1;
    // write beats 1 to 3 on the cycles after the command
    if (wr_left > 0) begin
      write_beat(wr_ptr, wr_data_s, mask_s);
      wr_ptr = wr_ptr + 1'b1;
      wr_left--;
    end
    br_rd_data_valid = 1'b0;
    if (rd_left > 0) begin
      if (rd_delay > 0) begin
        rd_delay--;
      end else begin
        br_rd_data = mem[rd_ptr];
        br_rd_data_valid = 1'b1;
        rd_ptr = rd_ptr + 1'b1;
        rd_left--;
      end
    end
    if (busy_left > 0) begin
      busy_left--;
    end
    if (cmd_en_s) begin
      if (cmd_s) begin
        // beat 0 comes with the command
        write_beat(addr_s, wr_data_s, mask_s);
        wr_ptr = addr_s + 1'b1;
        wr_left = beats_per_line - 1;
      end else begin
        // first beat three cycles after the command
        rd_ptr = addr_s;
        rd_left = beats_per_line;
        rd_delay = 2;
      end
      busy_left = 1 + ($random(seed) & 7);
    end
    br_busy = (busy_left > 0);
  end

endmodule

`default_nettype wire

// File: tb_data_cache.sv
// testbench for the direct-mapped write-back data cache
// directed tests against a burst RAM model and a reference memory

`timescale 1ns/1ns
`default_nettype none

module tb_data_cache
  import cache_pkg::*;
();

  localparam int line_ix_bits = 1;
  localparam int ram_addr_bits = 8;
  // the RAM holds 2 KB as 512 words
  localparam int ram_words = (2 ** ram_addr_bits) * words_per_beat;
  localparam int wait_limit = 100;

  logic clk;
  logic rst;
  logic enable;
  addr_t address;
  byte_en_t write_enable_bytes;
  word_t data_in;
  word_t data_out;
  logic data_out_ready;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  logic [ram_addr_bits-1:0] br_addr;
  beat_t br_wr_data;
  beat_mask_t br_data_mask;
  beat_t br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  // expected memory contents with one entry per word
  word_t ref_mem [ram_words];
  int seed;

  data_cache #(.line_ix_bits(line_ix_bits), .ram_addr_bits(ram_addr_bits)) i_data_cache (
    .clk, .rst, .enable, .address, .write_enable_bytes, .data_in, .data_out,
    .data_out_ready, .busy, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid, .br_busy
  );

  tb_burst_ram #(.addr_bits(ram_addr_bits), .busy_seed(32'h684f)) i_burst_ram (
    .clk, .rst, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_data_mask,
    .br_rd_data, .br_rd_data_valid, .br_busy
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic int word_index(input addr_t addr);
    return int'(addr[byte_offset_bits +: $clog2(ram_words)]);
  endfunction

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input byte_en_t be);
    word_t result;
    result = old_word;
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // one request that starts and ends 1 ns after a rising edge
  task automatic issue_request(input addr_t addr, input byte_en_t be, input word_t wdata,
                               output word_t rdata, output logic missed);
    int cycles;
    enable = 1'b1;
    address = addr;
    write_enable_bytes = be;
    data_in = wdata;
    @(posedge clk);
    #1;
    // a miss shows busy right after the acceptance edge
    missed = busy;
    cycles = 0;
    while (busy && cycles < wait_limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy) begin
      abort_run("timeout: busy did not fall after a miss");
    end
    rdata = data_out;
    check_value("data_out_ready", word_t'(data_out_ready), word_t'(be == '0));
    enable = 1'b0;
    write_enable_bytes = '0;
    // read pulse is a single cycle
    if (be == '0) begin
      @(posedge clk);
      #1;
      check_value("data_out_ready", word_t'(data_out_ready), 32'h0);
    end
  endtask

  task automatic read_check(input addr_t addr, output word_t rdata, output logic missed);
    issue_request(addr, '0, '0, rdata, missed);
    check_value("data_out", rdata, ref_mem[word_index(addr)]);
  endtask

  task automatic write_update(input addr_t addr, input byte_en_t be, input word_t wdata,
                              output logic missed);
    word_t rdata;
    issue_request(addr, be, wdata, rdata, missed);
    ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], wdata, be);
  endtask

  task automatic test_read_miss_clean();
    word_t rdata;
    logic missed;
    read_check(32'h0000_0040, rdata, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h1);
  endtask

  task automatic test_read_hit();
    word_t rdata;
    logic missed;
    // same line as the previous miss
    read_check(32'h0000_0048, rdata, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h0);
    check_value("busy", word_t'(busy), 32'h0);
  endtask

  task automatic test_write_hit_bytes();
    word_t old_word;
    word_t rdata;
    logic missed;
    old_word = ref_mem[word_index(32'h0000_0044)];
    write_update(32'h0000_0044, 4'b0101, 32'ha1b2c3d4, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h0);
    read_check(32'h0000_0044, rdata, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h0);
    // lanes 0 and 2 take the new bytes and lanes 1 and 3 keep the old ones
    check_value("data_out", rdata, {old_word[31:24], 8'hb2, old_word[15:8], 8'hd4});
  endtask

  task automatic test_dirty_eviction();
    word_t rdata;
    logic missed;
    write_update(32'h0000_0040, 4'b1111, 32'h1234_5678, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h0);
    // same line index 0 with tag 5 instead of 1
    read_check(32'h0000_0140, rdata, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h1);
    // words 0x40 and 0x44 share RAM beat 8
    check_value("ram word 0x40", i_burst_ram.mem[8][31:0], ref_mem[word_index(32'h40)]);
    check_value("ram word 0x44", i_burst_ram.mem[8][63:32], ref_mem[word_index(32'h44)]);
    read_check(32'h0000_0040, rdata, missed);
    check_value("busy after acceptance", word_t'(missed), 32'h1);
  endtask

  task automatic test_random_mix();
    logic [31:0] rnd;
    addr_t addr;
    byte_en_t be;
    word_t wdata;
    word_t rdata;
    logic missed;
    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      wdata = $random(seed);
      // 64 words give four tags on each of the two lines
      addr = {24'h0, rnd[5:0], 2'b00};
      be = rnd[8] ? rnd[12:9] : 4'b0000;
      if (be == '0) begin
        read_check(addr, rdata, missed);
      end else begin
        write_update(addr, be, wdata, missed);
      end
    end
  endtask

  initial begin
    seed = 32'h684f;
    rst = 1'b1;
    enable = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    for (int n = 0; n < ram_words; n++) begin
      ref_mem[n] = word_t'(n) ^ 32'h5a5a0000;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("busy", word_t'(busy), 32'h0);
    check_value("data_out_ready", word_t'(data_out_ready), 32'h0);
    check_value("br_cmd_en", word_t'(br_cmd_en), 32'h0);
    test_read_miss_clean();
    test_read_hit();
    test_write_hit_bytes();
    test_dirty_eviction();
    test_random_mix();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
